/* sad_trigger.f */
rtl/sad_cfg_pkg.sv
rtl/sad_stream_pkg.sv
rtl/sad_regs.sv
rtl/sad_step_feeder.sv
rtl/sad_lane.sv
rtl/sad_trigger_combiner.sv
rtl/sad_trigger.sv
verif/sad_trigger_tb.sv

/* Bender.yml */
package:
  name: sad_trigger

sources:
  - rtl/sad_cfg_pkg.sv
  - rtl/sad_stream_pkg.sv
  - rtl/sad_regs.sv
  - rtl/sad_step_feeder.sv
  - rtl/sad_lane.sv
  - rtl/sad_trigger_combiner.sv
  - rtl/sad_trigger.sv
  - target: test
    files:
      - verif/sad_trigger_tb.sv

/* verif/sad_trigger_tb.sv */
`default_nettype none

module sad_trigger_tb;

    localparam int REF_SAMPLES  = 8;
    localparam int SAD_WIDTH    = 10;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int REG_OPS      = 120; // bus cycles over all tests, rounded up
    localparam int LONG_RUN     = 200;
    localparam int SHORT_RUN    = 60;
    localparam int DRAIN        = 12;
    localparam int STIM_CYCLES  = RESET_CYCLES + REG_OPS + 2 * LONG_RUN + 7 * SHORT_RUN
                                  + 10 * DRAIN;
    localparam int MAXC         = 2 * STIM_CYCLES + 8;

    logic adc_sampleclk;
    logic reset;
    logic xadc_error;
    sad_stream_pkg::sample_t adc_datain;
    logic armed_and_ready;
    logic active;
    sad_cfg_pkg::sad_reg_e reg_address;
    logic [sad_cfg_pkg::BYTECNT_BITS-1:0] reg_bytecnt;
    sad_cfg_pkg::reg_byte_t reg_datai;
    logic reg_read;
    logic reg_write;
    sad_cfg_pkg::reg_byte_t reg_datao;
    logic trigger;

    // values applied at the next rising edge
    logic nx_reset;
    logic nx_xadc;
    sad_stream_pkg::sample_t nx_sample;
    logic nx_armed;
    logic nx_active;
    sad_cfg_pkg::sad_reg_e nx_addr;
    logic [sad_cfg_pkg::BYTECNT_BITS-1:0] nx_cnt;
    sad_cfg_pkg::reg_byte_t nx_datai;
    logic nx_read;
    logic nx_write;

    // model state, history indexed by the edge that samples the inputs
    sad_stream_pkg::sample_t ref_m [REF_SAMPLES];
    logic [REF_SAMPLES-1:0] en_m;
    logic [SAD_WIDTH-2:0] thr_m;
    sad_cfg_pkg::sad_mode_t mode_m;
    sad_cfg_pkg::trigger_status_t st_m;
    sad_stream_pkg::sample_t samp_h [MAXC];
    logic reset_h [MAXC];
    logic armed_h [MAXC];
    logic clr_h [MAXC];
    logic match_h [MAXC];
    logic trig_h [MAXC];
    int pos_h [MAXC]; // -1 when the feeder is not running
    int cyc;
    int seed;
    int phase;
    int errors;

    sad_trigger #(
        .ref_samples (REF_SAMPLES),
        .sad_width   (SAD_WIDTH)
    ) sad_trigger_i (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .xadc_error      (xadc_error),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .reg_address     (reg_address),
        .reg_bytecnt     (reg_bytecnt),
        .reg_datai       (reg_datai),
        .reg_read        (reg_read),
        .reg_write       (reg_write),
        .reg_datao       (reg_datao),
        .trigger         (trigger)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #(CLK_PERIOD / 2) adc_sampleclk = ~adc_sampleclk;
    end

    initial begin
        #(2 * STIM_CYCLES * CLK_PERIOD);
        $display("timeout: run took longer than %0d clock cycles", 2 * STIM_CYCLES);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    task automatic stop_on_error(string line);
        errors = errors + 1;
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic check_byte(string name, sad_cfg_pkg::reg_byte_t exp,
                              sad_cfg_pkg::reg_byte_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED time %0t signal %s expected %h actual %h",
                                    $time, name, exp, act));
    endtask

    task automatic check_trigger(logic exp, logic act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED time %0t signal trigger expected %b actual %b",
                                    $time, exp, act));
    endtask

    task automatic check_status(sad_cfg_pkg::trigger_status_t exp,
                                sad_cfg_pkg::trigger_status_t act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED time %0t signal status expected %h actual %h",
                                    $time, exp, act));
    endtask

    // true when some lane finishes a fully issued window whose last sample was at ls
    function automatic logic window_hit(int ls);
        int e0;
        int sad;
        int diff;
        logic full;
        logic hit;
        hit = 1'b0;
        for (int j = 0; j < REF_SAMPLES; j++) begin
            e0 = ls - j - REF_SAMPLES + 1;
            if (e0 >= 0) begin
                full = 1'b1;
                for (int k = 0; k < REF_SAMPLES; k++)
                    if (pos_h[e0 + k] != k)
                        full = 1'b0;
                if (full) begin
                    sad = 0;
                    for (int k = 0; k < REF_SAMPLES; k++) begin
                        diff = int'(samp_h[e0 + j + k]) - int'(ref_m[k]);
                        if (diff < 0)
                            diff = -diff;
                        if (en_m[k])
                            sad = sad + diff;
                    end
                    if (sad <= int'(thr_m)) // saturated sums exceed every threshold
                        hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    task automatic update_model(int c);
        if (reset_h[c]) begin
            match_h[c] = 1'b0;
            trig_h[c]  = 1'b0;
            st_m       = '0;
        end else begin
            match_h[c] = window_hit(c - 1);
            trig_h[c]  = match_h[c - 1] && !(st_m.triggered && !mode_m.multiple_triggers);
            if (clr_h[c - 1] || (armed_h[c] && !armed_h[c - 1])) begin
                st_m = '0;
            end else if (trig_h[c - 1] && !trig_h[c - 2]) begin
                st_m.triggered    = 1'b1;
                st_m.num_triggers = st_m.num_triggers + 16'd1;
            end
        end
    endtask

    task automatic tick();
        logic run_next;
        @(posedge adc_sampleclk);
        cyc = cyc + 1;
        update_model(cyc);
        reset           <= nx_reset;
        xadc_error      <= nx_xadc;
        adc_datain      <= nx_sample;
        armed_and_ready <= nx_armed;
        active          <= nx_active;
        reg_address     <= nx_addr;
        reg_bytecnt     <= nx_cnt;
        reg_datai       <= nx_datai;
        reg_read        <= nx_read;
        reg_write       <= nx_write;
        run_next = !nx_reset && (nx_armed || mode_m.always_armed) && nx_active && !nx_xadc;
        reset_h[cyc + 1] = nx_reset;
        samp_h[cyc + 1]  = nx_sample;
        armed_h[cyc + 1] = nx_armed && !nx_reset;
        clr_h[cyc + 1]   = nx_write && !nx_reset && (nx_addr == sad_cfg_pkg::SAD_STATUS);
        if (!run_next)
            pos_h[cyc + 1] = -1;
        else if (pos_h[cyc] >= 0 && pos_h[cyc] < REF_SAMPLES - 1)
            pos_h[cyc + 1] = pos_h[cyc] + 1;
        else
            pos_h[cyc + 1] = 0; // fresh start or wrap
        @(negedge adc_sampleclk);
        check_trigger(trig_h[cyc], trigger);
    endtask

    task automatic write_reg(sad_cfg_pkg::sad_reg_e addr, int cnt,
                             sad_cfg_pkg::reg_byte_t data);
        logic [31:0] wide;
        nx_addr  = addr;
        nx_cnt   = 7'(cnt);
        nx_datai = data;
        nx_write = 1'b1;
        tick();
        nx_write = 1'b0;
        case (addr)
            sad_cfg_pkg::SAD_REFERENCE: ref_m[cnt] = data;
            sad_cfg_pkg::SAD_REFEN:
                if (cnt == 0)
                    en_m = data[REF_SAMPLES-1:0];
            sad_cfg_pkg::SAD_THRESHOLD: begin
                wide = 32'(thr_m);
                wide[cnt * 8 +: 8] = data;
                thr_m = wide[SAD_WIDTH-2:0]; // upper bits are not stored
            end
            sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS: mode_m.multiple_triggers = data[0];
            sad_cfg_pkg::SAD_ALWAYS_ARMED:      mode_m.always_armed = data[0];
            default: ;
        endcase
    endtask

    task automatic read_reg(sad_cfg_pkg::sad_reg_e addr, int cnt,
                            output sad_cfg_pkg::reg_byte_t data);
        nx_addr = addr;
        nx_cnt  = 7'(cnt);
        nx_read = 1'b1;
        tick();
        data = reg_datao;
        nx_read = 1'b0;
    endtask

    task automatic expect_byte(sad_cfg_pkg::sad_reg_e addr, int cnt,
                               sad_cfg_pkg::reg_byte_t exp, string name);
        sad_cfg_pkg::reg_byte_t got;
        read_reg(addr, cnt, got);
        check_byte(name, exp, got);
    endtask

    task automatic verify_status();
        sad_cfg_pkg::reg_byte_t b0;
        sad_cfg_pkg::reg_byte_t b1;
        sad_cfg_pkg::reg_byte_t b2;
        sad_cfg_pkg::trigger_status_t act;
        read_reg(sad_cfg_pkg::SAD_STATUS, 0, b0);
        read_reg(sad_cfg_pkg::SAD_STATUS, 1, b1);
        read_reg(sad_cfg_pkg::SAD_STATUS, 2, b2);
        act.triggered    = b0[0];
        act.num_triggers = {b2, b1};
        check_status(st_m, act);
    endtask

    task automatic clear_by_write();
        write_reg(sad_cfg_pkg::SAD_STATUS, 0, 8'h00);
        nx_addr = sad_cfg_pkg::SAD_REFERENCE;
        repeat (2) tick(); // clear pulse lands one edge after the write
    endtask

    // base < 0 follows the reference with noise, else a flat level plus noise
    task automatic run_stream(int n, int base, logic armed, logic act, logic xerr);
        int v;
        nx_armed  = armed;
        nx_active = act;
        nx_xadc   = xerr;
        for (int i = 0; i < n; i++) begin
            v = $unsigned($random(seed)) % 13;
            if (base < 0)
                v = v - 6 + int'(ref_m[phase % REF_SAMPLES]);
            else
                v = v + base;
            if (v < 0)
                v = 0;
            if (v > 255)
                v = 255;
            nx_sample = v[7:0];
            phase = phase + 1;
            if ($unsigned($random(seed)) % 16 == 0)
                phase = phase + 1; // occasional slip in alignment
            tick();
        end
    endtask

    task automatic idle(int n);
        run_stream(n, -1, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        seed   = 86467;
        errors = 0;
        cyc    = 2;
        phase  = 0;
        for (int i = 0; i < MAXC; i++) begin
            samp_h[i]  = '0;
            reset_h[i] = 1'b0;
            armed_h[i] = 1'b0;
            clr_h[i]   = 1'b0;
            match_h[i] = 1'b0;
            trig_h[i]  = 1'b0;
            pos_h[i]   = -1;
        end
        for (int i = 0; i < REF_SAMPLES; i++)
            ref_m[i] = '0;
        en_m   = '1;
        thr_m  = '0;
        mode_m = '0;
        st_m   = '0;

        reset           = 1'b1;
        xadc_error      = 1'b0;
        adc_datain      = '0;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        reg_address     = sad_cfg_pkg::SAD_REFERENCE;
        reg_bytecnt     = '0;
        reg_datai       = '0;
        reg_read        = 1'b0;
        reg_write       = 1'b0;
        nx_reset  = 1'b1;
        nx_xadc   = 1'b0;
        nx_sample = '0;
        nx_armed  = 1'b0;
        nx_active = 1'b0;
        nx_addr   = sad_cfg_pkg::SAD_REFERENCE;
        nx_cnt    = '0;
        nx_datai  = '0;
        nx_read   = 1'b0;
        nx_write  = 1'b0;
        reset_h[cyc + 1] = 1'b1; // level present at the first edge
        repeat (RESET_CYCLES - 1) tick();
        nx_reset = 1'b0;

        // register access
        for (int i = 0; i < REF_SAMPLES; i++)
            write_reg(sad_cfg_pkg::SAD_REFERENCE, i, 8'($random(seed)));
        for (int i = 0; i < REF_SAMPLES; i++)
            expect_byte(sad_cfg_pkg::SAD_REFERENCE, i, ref_m[i], "reference");
        write_reg(sad_cfg_pkg::SAD_REFEN, 0, 8'($random(seed)));
        expect_byte(sad_cfg_pkg::SAD_REFEN, 0, 8'(en_m), "refen");
        write_reg(sad_cfg_pkg::SAD_THRESHOLD, 0, 8'($random(seed)));
        write_reg(sad_cfg_pkg::SAD_THRESHOLD, 1, 8'($random(seed)));
        for (int i = 0; i < 4; i++)
            expect_byte(sad_cfg_pkg::SAD_THRESHOLD, i, 8'(32'(thr_m) >> (8 * i)), "threshold");
        write_reg(sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS, 0, 8'($random(seed)));
        write_reg(sad_cfg_pkg::SAD_ALWAYS_ARMED, 0, 8'($random(seed)));
        expect_byte(sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS, 0, {7'b0, mode_m.multiple_triggers},
                    "multiple_triggers");
        expect_byte(sad_cfg_pkg::SAD_ALWAYS_ARMED, 0, {7'b0, mode_m.always_armed},
                    "always_armed");
        expect_byte(sad_cfg_pkg::SAD_REF_SAMPLES, 0, 8'd8, "ref_samples");
        expect_byte(sad_cfg_pkg::SAD_REF_SAMPLES, 1, 8'd0, "ref_samples");
        expect_byte(sad_cfg_pkg::SAD_COUNTER_WIDTH, 0, 8'd10, "counter_width");
        nx_addr = sad_cfg_pkg::SAD_COUNTER_WIDTH;
        nx_cnt  = '0;
        tick(); // read strobe low
        check_byte("reg_datao", 8'h00, reg_datao);
        expect_byte(sad_cfg_pkg::sad_reg_e'(8'h3c), 0, 8'h00, "reg_datao");

        // multiple triggers, random mask
        for (int i = 0; i < REF_SAMPLES; i++)
            write_reg(sad_cfg_pkg::SAD_REFERENCE, i, 8'($random(seed)));
        write_reg(sad_cfg_pkg::SAD_REFEN, 0, 8'($random(seed)));
        write_reg(sad_cfg_pkg::SAD_THRESHOLD, 0, 8'(12 + $unsigned($random(seed)) % 20));
        write_reg(sad_cfg_pkg::SAD_THRESHOLD, 1, 8'h00);
        write_reg(sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS, 0, 8'h01);
        write_reg(sad_cfg_pkg::SAD_ALWAYS_ARMED, 0, 8'h00);
        run_stream(LONG_RUN, -1, 1'b1, 1'b1, 1'b0);
        idle(DRAIN);
        verify_status();

        // single trigger
        write_reg(sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS, 0, 8'h00);
        clear_by_write();
        verify_status();
        run_stream(LONG_RUN, -1, 1'b1, 1'b1, 1'b0);
        idle(DRAIN);
        verify_status();
        clear_by_write();
        verify_status();

        // status cleared by a new arm edge
        write_reg(sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS, 0, 8'h01);
        run_stream(SHORT_RUN, -1, 1'b1, 1'b1, 1'b0);
        idle(DRAIN);
        run_stream(2, -1, 1'b1, 1'b0, 1'b0);
        idle(2);
        verify_status();

        // run gating
        run_stream(SHORT_RUN, -1, 1'b1, 1'b0, 1'b0);
        run_stream(SHORT_RUN, -1, 1'b1, 1'b1, 1'b1);
        run_stream(SHORT_RUN, -1, 1'b0, 1'b1, 1'b0);
        idle(DRAIN);
        verify_status();
        write_reg(sad_cfg_pkg::SAD_ALWAYS_ARMED, 0, 8'h01);
        run_stream(SHORT_RUN, -1, 1'b0, 1'b1, 1'b0);
        idle(DRAIN);
        write_reg(sad_cfg_pkg::SAD_ALWAYS_ARMED, 0, 8'h00);
        verify_status();

        // saturation, sums straddle 512 against a zero reference
        for (int i = 0; i < REF_SAMPLES; i++)
            write_reg(sad_cfg_pkg::SAD_REFERENCE, i, 8'h00);
        write_reg(sad_cfg_pkg::SAD_REFEN, 0, 8'hff);
        write_reg(sad_cfg_pkg::SAD_THRESHOLD, 0, 8'hff);
        write_reg(sad_cfg_pkg::SAD_THRESHOLD, 1, 8'h01);
        run_stream(SHORT_RUN, 58, 1'b1, 1'b1, 1'b0);
        // sums past 1024 would wrap under the threshold without saturation
        run_stream(SHORT_RUN, 160, 1'b1, 1'b1, 1'b0);
        idle(DRAIN);
        verify_status();

        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/sad_trigger.sv */
`default_nettype none

module sad_trigger #(
    parameter int ref_samples = 32, // at most 128
    parameter int sad_width   = 16
) (
    input  wire                                        adc_sampleclk,
    input  wire                                        reset,
    input  wire                                        xadc_error,
    input  wire sad_stream_pkg::sample_t               adc_datain,
    input  wire                                        armed_and_ready,
    input  wire                                        active,
    input  wire sad_cfg_pkg::sad_reg_e                 reg_address,
    input  wire logic [sad_cfg_pkg::BYTECNT_BITS-1:0]  reg_bytecnt,
    input  wire sad_cfg_pkg::reg_byte_t                reg_datai,
    input  wire                                        reg_read,
    input  wire                                        reg_write,
    output sad_cfg_pkg::reg_byte_t                     reg_datao,
    output logic                                       trigger
);

    sad_stream_pkg::sample_t [ref_samples-1:0] refsamples;
    logic [ref_samples-1:0] refen;
    logic [sad_width-2:0] threshold;
    sad_cfg_pkg::sad_mode_t mode;
    sad_cfg_pkg::trigger_status_t status;
    logic clear_status;

    sad_stream_pkg::sample_t sample;
    sad_stream_pkg::ref_step_t [ref_samples:0] step_chain; // entry j feeds lane j
    logic [ref_samples-1:0] match;

    sad_regs #(
        .ref_samples (ref_samples),
        .sad_width   (sad_width)
    ) u_regs (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .reg_address   (reg_address),
        .reg_bytecnt   (reg_bytecnt),
        .reg_datai     (reg_datai),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .status        (status),
        .reg_datao     (reg_datao),
        .refsamples    (refsamples),
        .refen         (refen),
        .threshold     (threshold),
        .mode          (mode),
        .clear_status  (clear_status)
    );

    sad_step_feeder #(
        .ref_samples (ref_samples)
    ) u_feeder (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .xadc_error      (xadc_error),
        .mode            (mode),
        .refsamples      (refsamples),
        .refen           (refen),
        .step            (step_chain[0]),
        .sample          (sample)
    );

    // one lane per window start, reference steps ripple down the chain
    for (genvar j = 0; j < ref_samples; j++) begin : gen_lane
        sad_lane #(
            .sad_width (sad_width)
        ) u_lane (
            .adc_sampleclk (adc_sampleclk),
            .reset         (reset),
            .step_in       (step_chain[j]),
            .sample        (sample),
            .threshold     (threshold),
            .step_out      (step_chain[j+1]),
            .match         (match[j])
        );
    end

    sad_trigger_combiner #(
        .ref_samples (ref_samples)
    ) u_combiner (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .match           (match),
        .armed_and_ready (armed_and_ready),
        .clear_status    (clear_status),
        .mode            (mode),
        .trigger         (trigger),
        .status          (status)
    );

endmodule

`default_nettype wire

/* rtl/sad_trigger_combiner.sv */
`default_nettype none

module sad_trigger_combiner #(
    parameter int ref_samples = 32
) (
    input  wire                              adc_sampleclk,
    input  wire                              reset,
    input  wire logic [ref_samples-1:0]      match,
    input  wire                              armed_and_ready,
    input  wire                              clear_status,
    input  wire sad_cfg_pkg::sad_mode_t      mode,
    output logic                             trigger,
    output sad_cfg_pkg::trigger_status_t     status
);

    logic any_match;
    logic blocked;
    logic trigger_d;
    logic armed_d;
    logic arm_rise;
    logic trigger_rise;

    assign any_match = |match;
    // single-trigger mode, hold off once fired
    assign blocked = status.triggered && !mode.multiple_triggers;

    assign arm_rise = armed_and_ready && !armed_d;
    assign trigger_rise = trigger && !trigger_d;

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            trigger   <= 1'b0;
            trigger_d <= 1'b0;
            armed_d   <= 1'b0;
        end else begin
            trigger   <= any_match && !blocked;
            trigger_d <= trigger;
            armed_d   <= armed_and_ready;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            status <= '0;
        end else if (clear_status || arm_rise) begin
            status <= '0; // clear takes priority over a new count
        end else if (trigger_rise) begin
            status.triggered    <= 1'b1;
            status.num_triggers <= status.num_triggers + 16'd1;
        end
    end

    a_single_holdoff: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        (status.triggered && !mode.multiple_triggers) |=> !trigger
    );

endmodule

`default_nettype wire

/* rtl/sad_lane.sv */
`default_nettype none

module sad_lane #(
    parameter int sad_width = 16
) (
    input  wire                             adc_sampleclk,
    input  wire                             reset,
    input  wire sad_stream_pkg::ref_step_t  step_in,
    input  wire sad_stream_pkg::sample_t    sample,
    input  wire logic [sad_width-2:0]       threshold,
    output sad_stream_pkg::ref_step_t       step_out,
    output logic                            match
);

    localparam int SAMPLE_BITS = sad_stream_pkg::SAMPLE_BITS;

    logic [SAMPLE_BITS-1:0] abs_diff;
    logic [sad_width-1:0] incr;
    logic [sad_width-1:0] counter;
    logic [sad_width-1:0] counter_next;

    always_comb begin
        if (sample > step_in.ref_sample)
            abs_diff = sample - step_in.ref_sample;
        else
            abs_diff = step_in.ref_sample - sample;
    end

    assign incr = step_in.enable ? {{(sad_width-SAMPLE_BITS){1'b0}}, abs_diff} : '0;

    // MSB set means saturated, value frozen until next window
    always_comb begin
        if (step_in.first)
            counter_next = incr;
        else if (counter[sad_width-1])
            counter_next = counter;
        else
            counter_next = counter + incr;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (step_in.valid)
            counter <= counter_next;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            step_out <= '0;
            match    <= 1'b0;
        end else begin
            step_out <= step_in; // next lane sees it one cycle later
            // threshold is one bit narrower so a saturated window fails here
            match <= step_in.valid && step_in.last && (counter_next <= threshold);
        end
    end

    a_match_at_end: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        match |-> $past(step_in.valid && step_in.last)
    );

endmodule

`default_nettype wire

/* rtl/sad_step_feeder.sv */
`default_nettype none

module sad_step_feeder #(
    parameter int ref_samples = 32
) (
    input  wire                                       adc_sampleclk,
    input  wire                                       reset,
    input  wire sad_stream_pkg::sample_t              adc_datain,
    input  wire                                       armed_and_ready,
    input  wire                                       active,
    input  wire                                       xadc_error,
    input  wire sad_cfg_pkg::sad_mode_t               mode,
    input  wire sad_stream_pkg::sample_t [ref_samples-1:0] refsamples,
    input  wire logic [ref_samples-1:0]               refen,
    output sad_stream_pkg::ref_step_t                 step,
    output sad_stream_pkg::sample_t                   sample
);

    localparam int POS_BITS = (ref_samples > 1) ? $clog2(ref_samples) : 1;
    localparam logic [POS_BITS-1:0] LAST_POS = POS_BITS'(ref_samples - 1);

    logic run;
    logic at_last;
    logic [POS_BITS-1:0] pos; // reference position issued at the next edge

    assign run = (armed_and_ready || mode.always_armed) && active && !xadc_error;
    assign at_last = (pos == LAST_POS);

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            pos  <= '0;
            step <= '0;
        end else begin
            step.valid      <= run;
            step.enable     <= refen[pos];
            step.first      <= (pos == '0);
            step.last       <= at_last;
            step.ref_sample <= refsamples[pos];
            if (!run)
                pos <= '0; // next run starts a fresh window set
            else if (at_last)
                pos <= '0;
            else
                pos <= pos + 1'b1;
        end
    end

    // one register stage, shared by every lane
    always_ff @(posedge adc_sampleclk) begin
        sample <= adc_datain;
    end

    a_pos_range: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        pos < ref_samples
    );

endmodule

`default_nettype wire

/* rtl/sad_regs.sv */
`default_nettype none

module sad_regs #(
    parameter int ref_samples = 32,
    parameter int sad_width   = 16
) (
    input  wire                                            adc_sampleclk,
    input  wire                                            reset,
    input  wire sad_cfg_pkg::sad_reg_e                     reg_address,
    input  wire logic [sad_cfg_pkg::BYTECNT_BITS-1:0]      reg_bytecnt,
    input  wire sad_cfg_pkg::reg_byte_t                    reg_datai,
    input  wire                                            reg_read,
    input  wire                                            reg_write,
    input  wire sad_cfg_pkg::trigger_status_t              status,
    output sad_cfg_pkg::reg_byte_t                         reg_datao,
    output sad_stream_pkg::sample_t [ref_samples-1:0]      refsamples,
    output logic [ref_samples-1:0]                         refen,
    output logic [sad_width-2:0]                           threshold,
    output sad_cfg_pkg::sad_mode_t                         mode,
    output logic                                           clear_status
);

    localparam int BYTE_BITS   = sad_cfg_pkg::REG_DATA_BITS;
    localparam int WIDE_BITS   = sad_cfg_pkg::WIDE_REG_BITS;
    localparam int WIDE_BYTES  = 4;
    localparam int REFEN_BYTES = (ref_samples + 7) / 8;
    localparam logic [15:0] REF_SAMPLES_WORD = 16'(ref_samples);
    localparam logic [7:0]  COUNTER_WIDTH_BYTE = 8'(sad_width);

    logic [REFEN_BYTES*BYTE_BITS-1:0] refen_bytes; // padded up to whole bytes
    logic [WIDE_BITS-1:0] threshold_wide;
    logic [WIDE_BITS-1:0] threshold_wr;
    logic [WIDE_BITS-1:0] status_wide;
    logic status_wr;
    logic status_wr_d;

    assign refen = refen_bytes[ref_samples-1:0];

    assign threshold_wide = {{(WIDE_BITS-sad_width+1){1'b0}}, threshold};
    assign status_wide = {8'h00, status.num_triggers, 7'h00, status.triggered};

    // threshold with the addressed byte replaced
    always_comb begin
        threshold_wr = threshold_wide;
        threshold_wr[reg_bytecnt[1:0]*BYTE_BITS +: BYTE_BITS] = reg_datai;
    end

    assign status_wr = reg_write && (reg_address == sad_cfg_pkg::SAD_STATUS);

    always_comb begin
        reg_datao = '0;
        if (reg_read) begin
            case (reg_address)
                sad_cfg_pkg::SAD_REFERENCE:
                    if (reg_bytecnt < ref_samples)
                        reg_datao = refsamples[reg_bytecnt];
                sad_cfg_pkg::SAD_REFEN:
                    if (reg_bytecnt < REFEN_BYTES)
                        reg_datao = refen_bytes[reg_bytecnt*BYTE_BITS +: BYTE_BITS];
                sad_cfg_pkg::SAD_THRESHOLD:
                    if (reg_bytecnt < WIDE_BYTES)
                        reg_datao = threshold_wide[reg_bytecnt[1:0]*BYTE_BITS +: BYTE_BITS];
                sad_cfg_pkg::SAD_STATUS:
                    if (reg_bytecnt < WIDE_BYTES)
                        reg_datao = status_wide[reg_bytecnt[1:0]*BYTE_BITS +: BYTE_BITS];
                sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS: reg_datao = {7'b0, mode.multiple_triggers};
                sad_cfg_pkg::SAD_ALWAYS_ARMED:      reg_datao = {7'b0, mode.always_armed};
                sad_cfg_pkg::SAD_REF_SAMPLES:
                    if (reg_bytecnt < 2)
                        reg_datao = REF_SAMPLES_WORD[reg_bytecnt[0]*BYTE_BITS +: BYTE_BITS];
                sad_cfg_pkg::SAD_COUNTER_WIDTH:     reg_datao = COUNTER_WIDTH_BYTE;
                default: ;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            refsamples   <= '0;
            refen_bytes  <= '1; // every position compared by default
            threshold    <= '0;
            mode         <= '0;
            status_wr_d  <= 1'b0;
            clear_status <= 1'b0;
        end else begin
            status_wr_d  <= status_wr;
            clear_status <= status_wr && !status_wr_d; // back-to-back writes give one pulse
            if (reg_write) begin
                case (reg_address)
                    sad_cfg_pkg::SAD_REFERENCE:
                        if (reg_bytecnt < ref_samples)
                            refsamples[reg_bytecnt] <= reg_datai;
                    sad_cfg_pkg::SAD_REFEN:
                        if (reg_bytecnt < REFEN_BYTES)
                            refen_bytes[reg_bytecnt*BYTE_BITS +: BYTE_BITS] <= reg_datai;
                    sad_cfg_pkg::SAD_THRESHOLD:
                        if (reg_bytecnt < WIDE_BYTES)
                            threshold <= threshold_wr[sad_width-2:0];
                    sad_cfg_pkg::SAD_MULTIPLE_TRIGGERS: mode.multiple_triggers <= reg_datai[0];
                    sad_cfg_pkg::SAD_ALWAYS_ARMED:      mode.always_armed <= reg_datai[0];
                    default: ;
                endcase
            end
        end
    end

    // combiner sees a single clear per status write burst
    a_clear_single: assert property (
        @(posedge adc_sampleclk) disable iff (reset)
        clear_status |=> !clear_status
    );

endmodule

`default_nettype wire

/* rtl/sad_stream_pkg.sv */
`default_nettype none

package sad_stream_pkg;

    localparam int SAMPLE_BITS = 8;

    typedef logic [SAMPLE_BITS-1:0] sample_t;

    // one reference position on its way down the lane chain
    typedef struct packed {
        logic    valid;
        logic    enable;     // mask bit, zero means skip this position
        logic    first;      // position 0, counter reloads
        logic    last;       // final position, match decided here
        sample_t ref_sample;
    } ref_step_t;

endpackage

`default_nettype wire

/* rtl/sad_cfg_pkg.sv */
`default_nettype none

package sad_cfg_pkg;

    localparam int BYTECNT_BITS  = 7;  // enough to address 128 reference bytes
    localparam int REG_DATA_BITS = 8;
    localparam int WIDE_REG_BITS = 32; // threshold and status as seen on the bus

    // register addresses on the byte bus
    typedef enum logic [7:0] {
        SAD_REFERENCE         = 8'h00,
        SAD_REFEN             = 8'h01,
        SAD_THRESHOLD         = 8'h02,
        SAD_STATUS            = 8'h03,
        SAD_MULTIPLE_TRIGGERS = 8'h04,
        SAD_ALWAYS_ARMED      = 8'h05,
        SAD_REF_SAMPLES       = 8'h06,
        SAD_COUNTER_WIDTH     = 8'h07
    } sad_reg_e;

    typedef logic [REG_DATA_BITS-1:0] reg_byte_t;

    // mode bits written through the bus
    typedef struct packed {
        logic multiple_triggers;
        logic always_armed;
    } sad_mode_t;

    typedef struct packed {
        logic [15:0] num_triggers; // wraps after 65535 trigger edges
        logic        triggered;
    } trigger_status_t;

endpackage

`default_nettype wire
